// File: Bender.yml
package:
  name: cpu16

sources:
  - rtl/cpuPkg.sv
  - rtl/fetchUnit.sv
  - rtl/memoryArbiter.sv
  - rtl/loadStoreUnit.sv
  - rtl/registerFile.sv
  - rtl/aluUnit.sv
  - rtl/executeController.sv
  - rtl/cpuTop.sv
  - target: test
    files:
      - testbench/tbMemoryModel.sv
      - testbench/cpuTb.sv

// File: flist.f
rtl/cpuPkg.sv
rtl/fetchUnit.sv
rtl/memoryArbiter.sv
rtl/loadStoreUnit.sv
rtl/registerFile.sv
rtl/aluUnit.sv
rtl/executeController.sv
rtl/cpuTop.sv
testbench/tbMemoryModel.sv
testbench/cpuTb.sv

// File: rtl/aluUnit.sv
`default_nettype none

module aluUnit import cpuPkg::*; (
    input  wire logic                 Clock,
    input  wire logic                 Reset,
    input  wire aluOpT                aluOp,
    input  wire logic [dataWidth-1:0] operandA,
    input  wire logic [dataWidth-1:0] operandB,
    input  wire logic                 flagUpdate,
    output logic [dataWidth-1:0]      aluResult,
    output logic                      zero
);

    always_comb begin
        case (aluOp)
            aluPass: aluResult = operandA;
            aluAdd:  aluResult = operandA + operandB;
            aluSub:  aluResult = operandA - operandB;
            aluAnd:  aluResult = operandA & operandB;
            aluOrr:  aluResult = operandA | operandB;
            aluXor:  aluResult = operandA ^ operandB;
            aluInc:  aluResult = operandA + dataWidth'(1);
            aluDec:  aluResult = operandA - dataWidth'(1);
            default: aluResult = '0;
        endcase
    end

    // Only Z is kept, BNE is its one reader
    always_ff @(posedge Clock or negedge Reset) begin
        if (!Reset) begin
            zero <= 1'b0;
        end else if (flagUpdate) begin
            zero <= (aluResult == '0);
        end
    end

endmodule

`default_nettype wire

// File: rtl/cpuPkg.sv
`default_nettype none

package cpuPkg;

    localparam int dataWidth = 16;   // Register and ALU width
    localparam int addrWidth = 16;
    localparam int byteWidth = 8;    // Memory port width

    ////////////////////////////////////////////////////////////
    // Opcodes and ALU functions
    ////////////////////////////////////////////////////////////

    typedef enum logic [5:0] {
        opBra   = 6'h00,
        opBne   = 6'h01,
        opInc   = 6'h05,
        opDec   = 6'h06,
        opAnd   = 6'h0C,
        opOrr   = 6'h0D,
        opXor   = 6'h0F,
        opMovh  = 6'h11,
        opLdr   = 6'h12,
        opStr   = 6'h13,
        opAdd   = 6'h15,
        opSub   = 6'h17,
        opLdrim = 6'h20
    } opcodeT;

    typedef enum logic [2:0] {
        aluPass,
        aluAdd,
        aluSub,
        aluAnd,
        aluOrr,
        aluXor,
        aluInc,
        aluDec
    } aluOpT;

    typedef logic [2:0] regSelT;   // 3 is AR, 4 to 7 are R1 to R4

    ////////////////////////////////////////////////////////////
    // Instruction formats
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        opcodeT               opcode;
        logic [1:0]           rsel;
        logic [byteWidth-1:0] imm;     // Immediate or branch offset
    } instrAddrT;

    typedef struct packed {
        opcodeT opcode;
        logic   spare;                 // Bit 9
        regSelT dst;
        regSelT src1;
        regSelT src2;
    } instrRegT;

    typedef union packed {
        instrAddrT addr;
        instrRegT  regs;
    } instrT;

    typedef struct packed {
        logic                 valid;
        logic                 write;
        logic [addrWidth-1:0] address;
        logic [byteWidth-1:0] writeData;
    } memRequestT;

    typedef struct packed {
        logic                 enable;
        regSelT               sel;
        logic [dataWidth-1:0] data;
        logic                 highOnly;   // MOVH touches bits 15:8 only
    } regWriteT;

endpackage

`default_nettype wire

// File: rtl/cpuTop.sv
`default_nettype none

module cpuTop import cpuPkg::*; (
    input  wire logic                 Clock,
    input  wire logic                 Reset,
    output memRequestT                memBus,
    input  wire logic [byteWidth-1:0] memReadData
);

    ////////////////////////////////////////////////////////////
    // Memory port side
    ////////////////////////////////////////////////////////////

    memRequestT           fetchReq;
    memRequestT           lsuReq;
    logic                 fetchGrant;
    logic                 lsuGrant;
    logic                 instrValid;
    instrT                instr;
    logic                 instrTake;
    logic                 branchTaken;
    logic [byteWidth-1:0] branchOffset;

    ////////////////////////////////////////////////////////////
    // Data path side
    ////////////////////////////////////////////////////////////

    logic                 lsuStart;
    logic                 lsuWrite;
    logic [addrWidth-1:0] lsuAddress;
    logic [dataWidth-1:0] lsuStoreData;
    logic                 lsuDone;
    logic [dataWidth-1:0] lsuLoadData;
    regWriteT             regWrite;
    regSelT               readSelA;
    regSelT               readSelB;
    logic [dataWidth-1:0] readDataA;
    logic [dataWidth-1:0] readDataB;
    logic [dataWidth-1:0] arValue;
    aluOpT                aluOp;
    logic [dataWidth-1:0] operandA;
    logic [dataWidth-1:0] operandB;
    logic                 flagUpdate;
    logic [dataWidth-1:0] aluResult;
    logic                 zero;

    // Port names match the nets above one to one
    fetchUnit         uFetchUnit         (.*);
    memoryArbiter     uMemoryArbiter     (.*);
    loadStoreUnit     uLoadStoreUnit     (.*);
    registerFile      uRegisterFile      (.*);
    aluUnit           uAluUnit           (.*);
    executeController uExecuteController (.*);

endmodule

`default_nettype wire

// File: rtl/executeController.sv
`default_nettype none

module executeController import cpuPkg::*; (
    input  wire logic                 Clock,
    input  wire logic                 Reset,
    input  wire logic                 instrValid,
    input  wire instrT                instr,
    input  wire logic                 lsuDone,
    input  wire logic [dataWidth-1:0] lsuLoadData,
    input  wire logic [dataWidth-1:0] aluResult,
    input  wire logic                 zero,
    input  wire logic [dataWidth-1:0] readDataA,
    input  wire logic [dataWidth-1:0] readDataB,
    input  wire logic [dataWidth-1:0] arValue,
    output logic                      instrTake,
    output logic                      branchTaken,
    output logic [byteWidth-1:0]      branchOffset,
    output logic                      lsuStart,
    output logic                      lsuWrite,
    output logic [addrWidth-1:0]      lsuAddress,
    output logic [dataWidth-1:0]      lsuStoreData,
    output regWriteT                  regWrite,
    output regSelT                    readSelA,
    output regSelT                    readSelB,
    output aluOpT                     aluOp,
    output logic [dataWidth-1:0]      operandA,
    output logic [dataWidth-1:0]      operandB,
    output logic                      flagUpdate
);

    typedef enum logic {stIdle, stMemWait} execState;

    execState state;
    execState nextState;
    opcodeT   opcode;
    regSelT   rselCode;      // Rx of the address form
    regSelT   loadSel;       // Destination of the pending LDR
    logic     pendingLoad;

    assign opcode   = instr.addr.opcode;
    assign rselCode = {1'b1, instr.addr.rsel};

    assign operandA     = readDataA;
    assign operandB     = readDataB;
    assign lsuAddress   = arValue;
    assign lsuStoreData = readDataA;   // Latched by the LSU at start
    assign branchOffset = instr.addr.imm;

    ////////////////////////////////////////////////////////////
    // Decode and execute
    ////////////////////////////////////////////////////////////

    always_comb begin
        nextState         = state;
        instrTake         = 1'b0;
        branchTaken       = 1'b0;
        lsuStart          = 1'b0;
        lsuWrite          = 1'b0;
        readSelA          = instr.regs.src1;
        readSelB          = instr.regs.src2;
        aluOp             = aluPass;
        flagUpdate        = 1'b0;
        regWrite.enable   = 1'b0;
        regWrite.sel      = instr.regs.dst;
        regWrite.data     = aluResult;
        regWrite.highOnly = 1'b0;

        if (state == stMemWait) begin
            if (lsuDone) begin
                nextState       = stIdle;
                regWrite.enable = pendingLoad;   // STR writes no register
                regWrite.sel    = loadSel;
                regWrite.data   = lsuLoadData;
            end
        end else if (instrValid) begin
            instrTake = 1'b1;
            case (opcode)
                opAdd: aluOp = aluAdd;
                opSub: aluOp = aluSub;
                opAnd: aluOp = aluAnd;
                opOrr: aluOp = aluOrr;
                opXor: aluOp = aluXor;
                opInc: aluOp = aluInc;
                opDec: aluOp = aluDec;
                opLdrim: begin
                    regWrite.enable = 1'b1;
                    regWrite.sel    = rselCode;
                    regWrite.data   = dataWidth'(instr.addr.imm);
                end
                opMovh: begin
                    regWrite.enable   = 1'b1;
                    regWrite.sel      = rselCode;
                    regWrite.data     = {instr.addr.imm, {byteWidth{1'b0}}};
                    regWrite.highOnly = 1'b1;
                end
                opLdr, opStr: begin
                    readSelA  = rselCode;   // Store data from Rx
                    lsuStart  = 1'b1;
                    lsuWrite  = (opcode == opStr);
                    nextState = stMemWait;
                end
                opBra:   branchTaken = 1'b1;
                opBne:   branchTaken = !zero;
                default: ;   // Unknown opcodes retire as no-ops
            endcase
            if (aluOp != aluPass) begin
                flagUpdate      = 1'b1;
                regWrite.enable = 1'b1;
            end
        end
    end

    always_ff @(posedge Clock or negedge Reset) begin
        if (!Reset) begin
            state <= stIdle;
        end else begin
            state <= nextState;
        end
    end

    always_ff @(posedge Clock) begin
        if (lsuStart) begin
            loadSel     <= rselCode;
            pendingLoad <= !lsuWrite;
        end
    end

endmodule

`default_nettype wire

// File: rtl/fetchUnit.sv
`default_nettype none

module fetchUnit import cpuPkg::*; (
    input  wire logic                 Clock,
    input  wire logic                 Reset,
    input  wire logic                 fetchGrant,
    input  wire logic [byteWidth-1:0] memReadData,
    input  wire logic                 instrTake,
    input  wire logic                 branchTaken,
    input  wire logic [byteWidth-1:0] branchOffset,
    output memRequestT                fetchReq,
    output logic                      instrValid,
    output instrT                     instr
);

    logic [addrWidth-1:0] pc;
    logic [addrWidth-1:0] bufNextPc;   // Address after the buffered instruction
    logic [addrWidth-1:0] offsetExt;
    logic [byteWidth-1:0] lowByte;
    logic                 highPhase;   // Low byte held, high byte next
    logic                 bufValid;
    logic                 fetchOn;
    instrT                bufInstr;

    assign offsetExt = {{(addrWidth-byteWidth){branchOffset[byteWidth-1]}}, branchOffset};

    // Request held steady until granted or the buffer fills
    assign fetchReq.valid     = fetchOn && !bufValid;
    assign fetchReq.write     = 1'b0;
    assign fetchReq.address   = pc + addrWidth'(highPhase);
    assign fetchReq.writeData = '0;

    assign instrValid = bufValid;
    assign instr      = bufInstr;

    always_ff @(posedge Clock or negedge Reset) begin
        if (!Reset) begin
            pc        <= '0;
            highPhase <= 1'b0;
            bufValid  <= 1'b0;
            fetchOn   <= 1'b0;
        end else begin
            fetchOn <= 1'b1;   // Bus stays idle in the reset cycle
            if (branchTaken) begin
                pc        <= bufNextPc + offsetExt;   // Drops any half fetch
                highPhase <= 1'b0;
                bufValid  <= 1'b0;
            end else begin
                if (instrTake) begin
                    bufValid <= 1'b0;
                end
                if (fetchGrant) begin
                    highPhase <= !highPhase;
                    if (highPhase) begin
                        pc       <= pc + addrWidth'(2);
                        bufValid <= 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge Clock) begin
        if (fetchGrant && !highPhase) begin
            lowByte <= memReadData;
        end
        if (fetchGrant && highPhase) begin
            bufInstr  <= instrT'({memReadData, lowByte});   // Little endian pair
            bufNextPc <= pc + addrWidth'(2);
        end
    end

    takeNeedsValid: assert property (@(posedge Clock) disable iff (!Reset)
        instrTake |-> instrValid)
        else $error("instrTake with an empty instruction buffer");

endmodule

`default_nettype wire

// File: rtl/loadStoreUnit.sv
`default_nettype none

module loadStoreUnit import cpuPkg::*; (
    input  wire logic                 Clock,
    input  wire logic                 Reset,
    input  wire logic                 lsuStart,
    input  wire logic                 lsuWrite,
    input  wire logic [addrWidth-1:0] lsuAddress,
    input  wire logic [dataWidth-1:0] lsuStoreData,
    input  wire logic                 lsuGrant,
    input  wire logic [byteWidth-1:0] memReadData,
    output memRequestT                lsuReq,
    output logic                      lsuDone,
    output logic [dataWidth-1:0]      lsuLoadData
);

    logic                 busy;
    logic                 highPhase;   // Second byte at address+1
    logic                 writeOp;
    logic [addrWidth-1:0] baseAddr;
    logic [dataWidth-1:0] storeData;
    logic [byteWidth-1:0] lowByte;

    assign lsuReq.valid     = busy;
    assign lsuReq.write     = busy && writeOp;
    assign lsuReq.address   = baseAddr + addrWidth'(highPhase);
    assign lsuReq.writeData = highPhase ? storeData[dataWidth-1:byteWidth]
                                        : storeData[byteWidth-1:0];

    assign lsuDone     = busy && highPhase && lsuGrant;   // Second granted byte
    assign lsuLoadData = {memReadData, lowByte};

    always_ff @(posedge Clock or negedge Reset) begin
        if (!Reset) begin
            busy      <= 1'b0;
            highPhase <= 1'b0;
        end else if (lsuStart) begin
            busy      <= 1'b1;
            highPhase <= 1'b0;
        end else if (lsuGrant) begin
            highPhase <= !highPhase;
            if (highPhase) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge Clock) begin
        if (lsuStart) begin
            writeOp   <= lsuWrite;
            baseAddr  <= lsuAddress;
            storeData <= lsuStoreData;
        end
        if (lsuGrant && !highPhase) begin
            lowByte <= memReadData;
        end
    end

    startWhenIdle: assert property (@(posedge Clock) disable iff (!Reset)
        lsuStart |-> !busy)
        else $error("lsuStart while a transfer is in flight");

endmodule

`default_nettype wire

// File: rtl/memoryArbiter.sv
`default_nettype none

module memoryArbiter import cpuPkg::*; (
    input  wire logic       Clock,
    input  wire logic       Reset,
    input  wire memRequestT fetchReq,
    input  wire memRequestT lsuReq,
    output memRequestT      memBus,
    output logic            fetchGrant,
    output logic            lsuGrant
);

    // Data accesses always win and prefetch takes the idle cycles
    assign lsuGrant   = lsuReq.valid;
    assign fetchGrant = fetchReq.valid && !lsuReq.valid;
    assign memBus     = lsuReq.valid ? lsuReq : fetchReq;

    ////////////////////////////////////////////////////////////
    // Port checks
    ////////////////////////////////////////////////////////////

    // Fetch side is read only
    writeFromLsu: assert property (@(posedge Clock) disable iff (!Reset)
        memBus.valid && memBus.write |-> lsuGrant)
        else $error("Write reached the memory port without a load/store grant");

    // A stalled fetch keeps its address until the port frees up
    fetchHeld: assert property (@(posedge Clock) disable iff (!Reset)
        fetchReq.valid && !fetchGrant |=> fetchReq.valid && $stable(fetchReq.address))
        else $error("Fetch request changed while waiting for grant");

endmodule

`default_nettype wire

// File: rtl/registerFile.sv
`default_nettype none

module registerFile import cpuPkg::*; (
    input  wire logic            Clock,
    input  wire logic            Reset,
    input  wire regWriteT        regWrite,
    input  wire regSelT          readSelA,
    input  wire regSelT          readSelB,
    output logic [dataWidth-1:0] readDataA,
    output logic [dataWidth-1:0] readDataB,
    output logic [dataWidth-1:0] arValue
);

    logic [dataWidth-1:0] gpr [4];   // R1 to R4
    logic [dataWidth-1:0] ar;
    logic [dataWidth-1:0] oldValue;
    logic [dataWidth-1:0] newValue;

    // Codes below 4 read as zero
    assign readDataA = readSelA[2] ? gpr[readSelA[1:0]] : '0;
    assign readDataB = readSelB[2] ? gpr[readSelB[1:0]] : '0;
    assign arValue   = ar;

    assign oldValue = regWrite.sel[2] ? gpr[regWrite.sel[1:0]] : ar;
    assign newValue = regWrite.highOnly
                    ? {regWrite.data[dataWidth-1:byteWidth], oldValue[byteWidth-1:0]}
                    : regWrite.data;

    always_ff @(posedge Clock or negedge Reset) begin
        if (!Reset) begin
            for (int i = 0; i < 4; i++) begin
                gpr[i] <= '0;
            end
            ar <= '0;
        end else if (regWrite.enable) begin
            if (regWrite.sel[2]) begin
                gpr[regWrite.sel[1:0]] <= newValue;
            end else if (regWrite.sel == 3'd3) begin
                ar <= newValue;
            end   // PC and SP codes write nothing
        end
    end

endmodule

`default_nettype wire

// File: testbench/cpuTb.sv
`default_nettype none

module cpuTb import cpuPkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    logic                 Clock = 1'b0;
    logic                 Reset = 1'b0;
    memRequestT           memBus;
    logic [byteWidth-1:0] memReadData;

    logic [7:0]  refMem [65536];     // Model copy of the memory image
    logic [15:0] expAddr [256];
    logic [7:0]  expData [256];
    int          writeTest [256];    // Owning test of each expected write
    int          testLast [7];
    int          testEnd [7];        // First program address after each test
    int          testErrors [7];
    string       testName [7];
    int          expCount = 0;
    int          writeIdx = 0;
    int          readCount = 0;
    int          haltFetches = 0;
    int          reportTest = 0;
    int          otherErrors = 0;
    int          progPc;
    int          storePtr;
    int          haltAddr = 0;
    int          forbiddenAddr = 'h0500;
    logic [31:0] lfsr;
    bit          ready = 1'b0;

    cpuTop u_dut (.Clock(Clock), .Reset(Reset), .memBus(memBus), .memReadData(memReadData));

    tbMemoryModel uMemory (.Clock(Clock), .memBus(memBus), .memReadData(memReadData));

    always #5 Clock = ~Clock;

    ////////////////////////////////////////////////////////////
    // Program building
    ////////////////////////////////////////////////////////////

    function automatic logic [15:0] randomBits(int count);
        logic [15:0] value;
        logic        feedback;
        value = '0;
        for (int i = 0; i < count; i++) begin
            feedback = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];   // Taps 32 22 2 1
            lfsr     = {lfsr[30:0], feedback};
            value    = {value[14:0], feedback};
        end
        return value;
    endfunction

    function automatic logic [15:0] addrForm(opcodeT op, int rx, logic [7:0] imm);
        return {op, 2'(rx - 1), imm};   // rx is 1 to 4
    endfunction

    function automatic logic [15:0] regForm(opcodeT op, int dst, int src1, int src2);
        return {op, 1'b0, 3'(dst), 3'(src1), 3'(src2)};
    endfunction

    task automatic emit(logic [15:0] word);
        refMem[progPc]     = word[7:0];
        refMem[progPc + 1] = word[15:8];
        progPc += 2;
    endtask

    task automatic loadValue(int rx, logic [15:0] value);
        emit(addrForm(opLdrim, rx, value[7:0]));
        emit(addrForm(opMovh, rx, value[15:8]));
    endtask

    task automatic pointAr(int addr);
        loadValue(4, 16'(addr));
        emit(regForm(opOrr, 3, 7, 7));   // AR = R4
    endtask

    task automatic storeNext(int rx);
        pointAr(storePtr);
        emit(addrForm(opStr, rx, 8'h00));
        storePtr += 2;
    endtask

    task automatic buildProgram();
        opcodeT aluOps [7];
        int     loopCount;
        int     loopTop;
        aluOps   = '{opAdd, opSub, opAnd, opOrr, opXor, opInc, opDec};
        progPc   = 0;
        storePtr = 'h0400;
        for (int k = 0; k < 2; k++) begin
            loadValue(1, randomBits(16));
            storeNext(1);
        end
        testEnd[2] = progPc;
        for (int k = 0; k < 7; k++) begin
            loadValue(1, randomBits(16));
            loadValue(2, randomBits(16));
            emit(regForm(aluOps[k], 6, 4, 5));   // R3 = R1 op R2
            storeNext(3);
        end
        testEnd[3] = progPc;
        for (int k = 0; k < 2; k++) begin
            refMem['h0300 + 2 * k]     = 8'(randomBits(8));
            refMem['h0300 + 2 * k + 1] = 8'(randomBits(8));
            pointAr('h0300 + 2 * k);
            emit(addrForm(opLdr, 2, 8'h00));
            storeNext(2);
        end
        testEnd[4] = progPc;
        loopCount = 3 + int'(randomBits(2));
        emit(addrForm(opLdrim, 1, 8'(loopCount)));
        loadValue(2, 16'(storePtr));
        loopTop = progPc;
        emit(regForm(opOrr, 3, 5, 5));        // AR = R2
        emit(addrForm(opStr, 1, 8'h00));
        emit(regForm(opInc, 5, 5, 0));
        emit(regForm(opInc, 5, 5, 0));
        emit(regForm(opDec, 4, 4, 0));        // Z set once R1 reaches zero
        emit(addrForm(opBne, 1, 8'(loopTop - progPc - 2)));
        storePtr += 2 * loopCount;
        pointAr(forbiddenAddr);
        emit(addrForm(opBra, 1, 8'd2));       // Jumps over the next STR
        emit(addrForm(opStr, 1, 8'h00));
        loadValue(3, randomBits(16));
        storeNext(3);
        testEnd[5] = progPc;
        refMem['h0310] = 8'(randomBits(8));
        refMem['h0311] = 8'(randomBits(8));
        loadValue(2, randomBits(16));
        pointAr('h0310);
        emit(addrForm(opLdr, 1, 8'h00));
        emit(addrForm(opStr, 2, 8'h00));      // Overwrites the word just loaded
        emit(addrForm(opLdr, 3, 8'h00));
        pointAr(storePtr);
        emit(addrForm(opStr, 1, 8'h00));
        emit(addrForm(opStr, 3, 8'h00));      // Second store to the same address
        haltAddr = progPc;
        emit(addrForm(opBra, 1, 8'hFE));      // Branch to itself
    endtask

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    function automatic int testAt(int pc);
        for (int t = 2; t < 6; t++) begin
            if (pc < testEnd[t]) begin
                return t;
            end
        end
        return 6;
    endfunction

    task automatic expectWrite(logic [15:0] addr, logic [7:0] data, int test);
        expAddr[expCount]   = addr;
        expData[expCount]   = data;
        writeTest[expCount] = test;
        testLast[test]      = expCount;
        expCount++;
    endtask

    task automatic runModel();
        logic [15:0] regs [8];   // Index 3 is AR and 4 to 7 are R1 to R4
        logic [15:0] word;
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] result;
        logic [2:0]  rx;
        logic        zf;
        logic        isAlu;
        opcodeT      op;
        int          pc;
        for (int i = 0; i < 8; i++) begin
            regs[i] = '0;
        end
        zf = 1'b0;
        pc = 0;
        for (int step = 0; step < 4096; step++) begin
            word  = {refMem[pc + 1], refMem[pc]};
            op    = opcodeT'(word[15:10]);
            rx    = 3'(word[9:8]) + 3'd4;
            a     = (word[5:3] >= 3'd4) ? regs[word[5:3]] : '0;
            b     = (word[2:0] >= 3'd4) ? regs[word[2:0]] : '0;
            isAlu = 1'b1;
            case (op)
                opAdd:   result = a + b;
                opSub:   result = a - b;
                opAnd:   result = a & b;
                opOrr:   result = a | b;
                opXor:   result = a ^ b;
                opInc:   result = a + 16'd1;
                opDec:   result = a - 16'd1;
                default: isAlu = 1'b0;
            endcase
            if (isAlu) begin
                zf = (result == '0);
                if (word[8:6] >= 3'd3) begin
                    regs[word[8:6]] = result;
                end
            end
            if (op == opBra && word[7:0] == 8'hFE) begin
                break;
            end
            case (op)
                opLdrim: regs[rx] = {8'h00, word[7:0]};
                opMovh:  regs[rx][15:8] = word[7:0];
                opLdr:   regs[rx] = {refMem[regs[3] + 16'd1], refMem[regs[3]]};
                opStr: begin
                    expectWrite(regs[3], regs[rx][7:0], testAt(pc));
                    expectWrite(regs[3] + 16'd1, regs[rx][15:8], testAt(pc));
                    refMem[regs[3]]         = regs[rx][7:0];
                    refMem[regs[3] + 16'd1] = regs[rx][15:8];
                end
                default: ;
            endcase
            if (op == opBra || (op == opBne && !zf)) begin
                pc = pc + 2 + int'($signed(word[7:0]));   // Relative to next instruction
            end else begin
                pc = pc + 2;
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Checks on the memory port
    ////////////////////////////////////////////////////////////

    startAddress: assert property (@(posedge Clock) disable iff (!Reset)
        memBus.valid && readCount < 2 |-> memBus.address == 16'(readCount))
        else begin
            $display("[ERROR] memBus.address expected 0x%04h got 0x%04h",
                     16'($sampled(readCount)), $sampled(memBus.address));
            testErrors[1]++;
        end

    writeAddress: assert property (@(posedge Clock) disable iff (!Reset)
        memBus.valid && memBus.write && writeIdx < expCount |->
            memBus.address == expAddr[writeIdx])
        else begin
            $display("[ERROR] memBus.address expected 0x%04h got 0x%04h",
                     expAddr[$sampled(writeIdx)], $sampled(memBus.address));
            testErrors[writeTest[$sampled(writeIdx)]]++;
        end

    writeValue: assert property (@(posedge Clock) disable iff (!Reset)
        memBus.valid && memBus.write && writeIdx < expCount |->
            memBus.writeData == expData[writeIdx])
        else begin
            $display("[ERROR] memBus.writeData expected 0x%02h got 0x%02h",
                     expData[$sampled(writeIdx)], $sampled(memBus.writeData));
            testErrors[writeTest[$sampled(writeIdx)]]++;
        end

    noExtraWrite: assert property (@(posedge Clock) disable iff (!Reset)
        memBus.valid && memBus.write |-> writeIdx < expCount)
        else begin
            $display("A data write appeared after all expected writes were seen");
            otherErrors++;
        end

    programIntact: assert property (@(posedge Clock) disable iff (!Reset)
        memBus.valid && memBus.write |-> memBus.address >= 16'(haltAddr + 2))
        else begin
            $display("A write landed inside the program region");
            testErrors[6]++;
        end

    skipHonored: assert property (@(posedge Clock) disable iff (!Reset)
        memBus.valid && memBus.write |-> memBus.address[15:1] != 15'(forbiddenAddr >> 1))
        else begin
            $display("The STR skipped by BRA wrote to memory");
            testErrors[5]++;
        end

    // One report per finished test on the next falling edge
    always @(posedge Clock) begin
        reportTest <= 0;
        if (Reset && memBus.valid) begin
            if (readCount < 2) begin
                readCount <= readCount + 1;
                if (readCount == 1) begin
                    reportTest <= 1;
                end
            end
            if (memBus.write && writeIdx < expCount) begin
                writeIdx <= writeIdx + 1;
                if (testLast[writeTest[writeIdx]] == writeIdx) begin
                    reportTest <= writeTest[writeIdx];
                end
            end
            if (!memBus.write && writeIdx == expCount && memBus.address == 16'(haltAddr)) begin
                haltFetches <= haltFetches + 1;
            end
        end
    end

    always @(negedge Clock) begin
        if (reportTest != 0) begin
            $display("Test %0d, %s: %s", reportTest, testName[reportTest],
                     (testErrors[reportTest] == 0) ? "ok" : "FAILED");
        end
    end

    ////////////////////////////////////////////////////////////
    // Main sequence and watchdog
    ////////////////////////////////////////////////////////////

    initial begin
        int passed;
        int failed;
        lfsr = 32'hecc0_b1dc;
        testName = '{"", "reset and fetch start", "immediate loads and stores",
                     "ALU operations", "load then store", "branches",
                     "arbitration under contention"};
        for (int t = 0; t < 7; t++) begin
            testErrors[t] = 0;
            testLast[t]   = -1;
        end
        for (int a = 0; a < 65536; a++) begin
            refMem[a] = 8'(a) ^ 8'(a >> 8) ^ 8'h5A;   // Depends on all address bits
        end
        buildProgram();
        for (int a = 0; a < 65536; a++) begin
            uMemory.mem[a] = refMem[a];
        end
        runModel();   // Model stores change refMem after the copy
        ready = 1'b1;
        repeat (3) @(negedge Clock);
        Reset = 1'b1;
        wait (writeIdx == expCount && haltFetches >= 2);
        passed = 0;
        failed = 0;
        for (int t = 1; t < 7; t++) begin
            if (testErrors[t] == 0) begin
                passed++;
            end else begin
                failed++;
            end
        end
        $display("Tests passed %0d, failed %0d, other errors %0d", passed, failed, otherErrors);
        if (failed == 0 && otherErrors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin
        wait (ready);
        repeat (40 * (haltAddr / 2 + 1)) @(posedge Clock);   // 40 cycles per instruction
        $display("Timed out before the program reached its final branch");
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/tbMemoryModel.sv
`default_nettype none

module tbMemoryModel import cpuPkg::*; (
    input  wire logic            Clock,
    input  wire memRequestT      memBus,
    output logic [byteWidth-1:0] memReadData
);

    timeunit 1ns;
    timeprecision 1ps;

    logic [byteWidth-1:0] mem [2**addrWidth];   // Image loaded before reset

    assign memReadData = mem[memBus.address];    // Same-cycle read data

    always @(posedge Clock) begin
        if (memBus.valid && memBus.write) begin
            mem[memBus.address] <= memBus.writeData;
        end
    end

endmodule

`default_nettype wire
